// ==== bench/tb_lsu_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_wb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_WORDS    = 16;
    localparam int N_ALU      = 150;
    localparam int N_PAIRS    = 40;
    localparam int N_ALIGN_W  = 8;
    localparam int N_MIX      = 200;
    localparam int N_ROUNDS   = 20;
    // operations over all phases plus 32 for each register readback
    localparam int N_OPS = N_WORDS + N_ALU + 1 + 2 * N_PAIRS + 1 + 13 * N_ALIGN_W + 1
                         + N_MIX + 1 + 8 * N_ROUNDS + 2 * 32;

    logic              clk;
    logic              rst_n;
    logic              flush_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [1:0]        in_op_i;
    logic [XLEN-1:0]   in_addr_i;
    logic [XLEN-1:0]   in_wdata_i;
    logic [REG_AW-1:0] in_rd_i;
    logic [2:0]        in_funct3_i;
    logic              ret_valid_o;
    logic              ret_ready_i = 1'b0;
    logic [REG_AW-1:0] ret_rd_o;
    logic [XLEN-1:0]   ret_data_o;
    logic [REG_AW-1:0] rs_addr_i;
    logic [XLEN-1:0]   rs_data_o;

    integer            seed = 32'h3118a97f;
    integer            bp_seed = 32'h3118a97f ^ 32'h0000ffff;
    logic [31:0]       bp_r;
    int                err_ret;
    int                err_main;
    string             test_name;
    logic              bp_on;
    logic              hold_ret;
    logic [REG_AW-1:0] exp_rd;
    logic [XLEN-1:0]   exp_data;

    // expected results in retire order
    logic [REG_AW-1:0] exp_rd_q [$];
    logic [XLEN-1:0]   exp_data_q [$];
    logic [XLEN-1:0]   ram_model [N_WORDS];
    logic [XLEN-1:0]   reg_model [32];

    lsu_wb_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_op_i     (in_op_i),
        .in_addr_i   (in_addr_i),
        .in_wdata_i  (in_wdata_i),
        .in_rd_i     (in_rd_i),
        .in_funct3_i (in_funct3_i),
        .ret_valid_o (ret_valid_o),
        .ret_ready_i (ret_ready_i),
        .ret_rd_o    (ret_rd_o),
        .ret_data_o  (ret_data_o),
        .rs_addr_i   (rs_addr_i),
        .rs_data_o   (rs_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    // RV32 load rule picks the byte or halfword at the offset and extends it
    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
                                                   input logic [2:0] f3,
                                                   input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{off, 3'b000} +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            F3_LB:   load_value = {{24{b[7]}}, b};
            F3_LBU:  load_value = {24'h0, b};
            F3_LH:   load_value = {{16{h[15]}}, h};
            F3_LHU:  load_value = {16'h0, h};
            default: load_value = word;
        endcase
    endfunction

    task automatic send(input logic [1:0] op, input logic [XLEN-1:0] addr,
                        input logic [XLEN-1:0] wdata, input logic [REG_AW-1:0] rd,
                        input logic [2:0] f3);
        logic ok;
        in_valid_i  = 1'b1;
        in_op_i     = op;
        in_addr_i   = addr;
        in_wdata_i  = wdata;
        in_rd_i     = rd;
        in_funct3_i = f3;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = in_ready_o;
            @(posedge clk);
            #1;
        end
        in_valid_i = 1'b0;
        if (op == OP_STORE) begin
            ram_model[addr[5:2]] = wdata;
        end else if (op == OP_LOAD) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(load_value(ram_model[addr[5:2]], f3, addr[1:0]));
        end else begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(addr);
        end
    endtask

    task automatic send_alu();
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] r;
        a = rnd();
        w = rnd();
        r = rnd();
        send(OP_ALU, a, w, r[4:0], r[7:5]);
    endtask

    task automatic send_store(input logic [3:0] idx, input logic [XLEN-1:0] data);
        logic [31:0] r;
        r = rnd();
        send(OP_STORE, {26'h0, idx, 2'b00}, data, r[4:0], F3_LW);
    endtask

    task automatic send_load(input logic [3:0] idx, input logic [1:0] off,
                             input logic [2:0] f3);
        logic [31:0] r;
        r = rnd();
        send(OP_LOAD, {26'h0, idx, off}, r, r[12:8], f3);
    endtask

    task automatic send_rand_load();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [1:0]  off;
        r = rnd();
        case (r[2:0])
            3'd0, 3'd1: f3 = F3_LB;
            3'd2:       f3 = F3_LBU;
            3'd3, 3'd4: f3 = F3_LH;
            3'd5:       f3 = F3_LHU;
            default:    f3 = F3_LW;
        endcase
        off = r[5:4];
        // only aligned halfwords and words
        if (f3 == F3_LH || f3 == F3_LHU) begin
            off[0] = 1'b0;
        end
        if (f3 == F3_LW) begin
            off = 2'b00;
        end
        send_load(r[11:8], off, f3);
    endtask

    task automatic wait_idle();
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            rs_addr_i = i[4:0];
            @(negedge clk);
            if (rs_data_o !== reg_model[i]) begin
                err_main++;
                $display("Fail %s: x%0d expected %h actual %h",
                         test_name, i, reg_model[i], rs_data_o);
            end
            @(posedge clk);
            #1;
        end
    endtask

    // retire is held off in the flush cycle, so every queued op is dropped
    task automatic do_flush();
        hold_ret = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b1;
        exp_rd_q.delete();
        exp_data_q.delete();
        @(posedge clk);
        #1;
        flush_i  = 1'b0;
        hold_ret = 1'b0;
    endtask

    // retire back-pressure
    always @(posedge clk) begin
        #1;
        bp_r = $random(bp_seed);
        if (hold_ret) begin
            ret_ready_i = 1'b0;
        end else if (bp_on) begin
            ret_ready_i = (bp_r[1:0] != 2'b00);
        end else begin
            ret_ready_i = 1'b1;
        end
    end

    // a handshake seen here completes on the next rising edge
    always @(negedge clk) begin
        if (rst_n && ret_valid_o && ret_ready_i) begin
            if (exp_rd_q.size() == 0) begin
                err_ret++;
                $display("%s: a result retired with no operation outstanding", test_name);
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (ret_rd_o !== exp_rd) begin
                    err_ret++;
                    $display("Fail %s: ret_rd expected %0d actual %0d",
                             test_name, exp_rd, ret_rd_o);
                end
                if (ret_data_o !== exp_data) begin
                    err_ret++;
                    $display("Fail %s: ret_data expected %h actual %h",
                             test_name, exp_data, ret_data_o);
                end
                if (exp_rd != '0) begin
                    reg_model[exp_rd] = exp_data;
                end
            end
        end
    end

    initial begin
        #(N_OPS * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles without the tests finishing", N_OPS * 20);
        $display("error count: %0d on the retire port, %0d elsewhere", err_ret, err_main);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] pick;
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_op_i     = OP_ALU;
        in_addr_i   = '0;
        in_wdata_i  = '0;
        in_rd_i     = '0;
        in_funct3_i = '0;
        rs_addr_i   = '0;
        bp_on       = 1'b0;
        hold_ret    = 1'b0;
        err_ret     = 0;
        err_main    = 0;
        test_name   = "reset";
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (ret_valid_o !== 1'b0) begin
            err_main++;
            $display("ret_valid_o is not low after reset");
        end

        // every model word gets a defined value before any load
        for (int i = 0; i < N_WORDS; i++) begin
            send_store(i[3:0], rnd());
        end

        test_name = "alu";
        for (int i = 0; i < N_ALU; i++) begin
            if (i % 10 == 0) begin
                r = rnd();
                send(OP_ALU, r, ~r, 5'd0, F3_LW);
            end else begin
                send_alu();
            end
        end
        wait_idle();
        check_regs();

        test_name = "store_load";
        for (int i = 0; i < N_PAIRS; i++) begin
            r = rnd();
            send_store(r[3:0], rnd());
            send_load(r[3:0], 2'b00, F3_LW);
        end
        send_alu();
        wait_idle();

        test_name = "sub_word";
        for (int w = 0; w < N_ALIGN_W; w++) begin
            r = rnd();
            // both sign values among the bytes and among the halves
            r[31] = ~r[15];
            r[23] = r[15];
            r[7]  = ~r[15];
            send_store(w[3:0], r);
            for (int off = 0; off < 4; off++) begin
                send_load(w[3:0], off[1:0], F3_LB);
                send_load(w[3:0], off[1:0], F3_LBU);
            end
            for (int off = 0; off < 4; off += 2) begin
                send_load(w[3:0], off[1:0], F3_LH);
                send_load(w[3:0], off[1:0], F3_LHU);
            end
        end
        send_alu();
        wait_idle();

        test_name = "backpressure";
        bp_on = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            r = rnd();
            case (r[1:0])
                2'd0:    send_store(r[7:4], rnd());
                2'd3:    send_alu();
                default: send_rand_load();
            endcase
        end
        send_alu();
        wait_idle();

        test_name = "flush";
        for (int k = 0; k < N_ROUNDS; k++) begin
            r = rnd();
            repeat (1 + r[1:0]) begin
                pick = rnd();
                if (pick[0]) begin
                    send_rand_load();
                end else begin
                    send_alu();
                end
            end
            repeat (r[3:2]) begin
                @(posedge clk);
                #1;
            end
            do_flush();
            send_rand_load();
            send_alu();
            send_rand_load();
            send_alu();
            wait_idle();
        end
        bp_on = 1'b0;
        check_regs();

        $display("error count: %0d on the retire port, %0d elsewhere", err_ret, err_main);
        if (err_ret + err_main == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/lsu_pkg.sv
hw/pipe_if.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/mem_wb.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/lsu_wb_top.sv
bench/tb_lsu_wb.sv

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req_valid_i,
    output logic                       req_ready_o,
    input  wire                        req_we_i,
    input  wire [lsu_pkg::RAM_AW-1:0]  req_addr_i,
    input  wire [lsu_pkg::XLEN-1:0]    req_wdata_i,
    output logic                       data_ok_o,
    output logic [lsu_pkg::XLEN-1:0]   rdata_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0]   mem [2**RAM_AW];
    logic              busy_q;
    logic [1:0]        cnt_q;
    logic [RAM_AW-1:0] raddr_q;
    logic [7:0]        lfsr_q;
    logic              accept;

    assign req_ready_o = !busy_q;
    assign accept      = req_valid_i && !busy_q;

    // response comes in the cycle the countdown hits zero
    assign data_ok_o = busy_q && (cnt_q == 2'd0);
    assign rdata_o   = mem[raddr_q];

    // free running LFSR with x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= 2'd0;
        end else if (accept && !req_we_i) begin
            busy_q <= 1'b1;
            // latency of 1 to 4 cycles
            cnt_q  <= lfsr_q[1:0];
        end else if (data_ok_o) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req_we_i) begin
            mem[req_addr_i] <= req_wdata_i;
        end
        if (accept && !req_we_i) begin
            raddr_q <= req_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // data path and address widths
    localparam int XLEN   = 32;
    localparam int RAM_AW = 8;
    localparam int REG_AW = 5;

    // operation codes carried from execute
    localparam logic [1:0] OP_ALU   = 2'd0;
    localparam logic [1:0] OP_LOAD  = 2'd1;
    localparam logic [1:0] OP_STORE = 2'd2;

    // load funct3 encodings
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // one-hot bit positions of the mem_wb FSM
    localparam int S_EMPTY = 0;
    localparam int S_PIPE  = 1;
    localparam int S_FULL  = 2;
    localparam int S_DRAIN = 3;

    // nonzero start value of the latency LFSR in data_ram
    localparam logic [7:0] LFSR_SEED = 8'hb5;

    // a read word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_t;

endpackage

`default_nettype wire

// ==== hw/lsu_wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_wb_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush_i,
    input  wire                        in_valid_i,
    output logic                       in_ready_o,
    input  wire [1:0]                  in_op_i,
    input  wire [lsu_pkg::XLEN-1:0]    in_addr_i,
    input  wire [lsu_pkg::XLEN-1:0]    in_wdata_i,
    input  wire [lsu_pkg::REG_AW-1:0]  in_rd_i,
    input  wire [2:0]                  in_funct3_i,
    output logic                       ret_valid_o,
    input  wire                        ret_ready_i,
    output logic [lsu_pkg::REG_AW-1:0] ret_rd_o,
    output logic [lsu_pkg::XLEN-1:0]   ret_data_o,
    input  wire [lsu_pkg::REG_AW-1:0]  rs_addr_i,
    output logic [lsu_pkg::XLEN-1:0]   rs_data_o
);
    import lsu_pkg::*;

    logic              req_valid;
    logic              req_ready;
    logic              req_we;
    logic [RAM_AW-1:0] req_addr;
    logic [XLEN-1:0]   req_wdata;
    logic              data_ok;
    logic [XLEN-1:0]   rdata;

    pipe_if ms2mw ();
    pipe_if mw2wb ();

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_op_i     (in_op_i),
        .in_addr_i   (in_addr_i),
        .in_wdata_i  (in_wdata_i),
        .in_rd_i     (in_rd_i),
        .in_funct3_i (in_funct3_i),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .req_we_o    (req_we),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .down        (ms2mw.up)
    );

    data_ram u_data_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_we_i    (req_we),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata)
    );

    mem_wb u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush_i   (flush_i),
        .data_ok_i (data_ok),
        .rdata_i   (rdata),
        .up        (ms2mw.down),
        .down      (mw2wb.up)
    );

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .up          (mw2wb.down),
        .ret_valid_o (ret_valid_o),
        .ret_ready_i (ret_ready_i),
        .ret_rd_o    (ret_rd_o),
        .ret_data_o  (ret_data_o)
    );

    // write on the retire handshake
    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we_i  (ret_valid_o && ret_ready_i),
        .wa_i  (ret_rd_o),
        .wd_i  (ret_data_o),
        .ra_i  (rs_addr_i),
        .rd_o  (rs_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush_i,
    input  wire                        in_valid_i,
    output logic                       in_ready_o,
    input  wire [1:0]                  in_op_i,
    input  wire [lsu_pkg::XLEN-1:0]    in_addr_i,
    input  wire [lsu_pkg::XLEN-1:0]    in_wdata_i,
    input  wire [lsu_pkg::REG_AW-1:0]  in_rd_i,
    input  wire [2:0]                  in_funct3_i,
    output logic                       req_valid_o,
    input  wire                        req_ready_i,
    output logic                       req_we_o,
    output logic [lsu_pkg::RAM_AW-1:0] req_addr_o,
    output logic [lsu_pkg::XLEN-1:0]   req_wdata_o,
    pipe_if.up                         down
);
    import lsu_pkg::*;

    logic              valid_q;
    logic [1:0]        op_q;
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [REG_AW-1:0] rd_q;
    logic [2:0]        funct3_q;
    logic              is_load;
    logic              is_store;
    logic              leave;

    assign is_load  = (op_q == OP_LOAD);
    assign is_store = (op_q == OP_STORE);

    // a load is only issued when mem_wb can take it on the same edge
    assign req_valid_o = valid_q && !flush_i && (is_store || (is_load && down.ready));
    assign req_we_o    = is_store;
    assign req_addr_o  = addr_q[RAM_AW+1:2];
    assign req_wdata_o = wdata_q;

    // stores end here and loads follow their RAM request
    assign down.valid  = valid_q && (!(is_load || is_store) || (is_load && req_ready_i));
    assign down.op     = op_q;
    assign down.addr   = addr_q;
    assign down.wdata  = wdata_q;
    assign down.rd     = rd_q;
    assign down.funct3 = funct3_q;

    assign leave = is_store ? (req_valid_o && req_ready_i) : (down.valid && down.ready);

    assign in_ready_o = !flush_i && (!valid_q || leave);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (leave) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            op_q     <= in_op_i;
            addr_q   <= in_addr_i;
            wdata_q  <= in_wdata_i;
            rd_q     <= in_rd_i;
            funct3_q <= in_funct3_i;
        end
    end

    // RAM request must hold steady until the RAM takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n || flush_i)
        req_valid_o && !req_ready_i |=>
            req_valid_o && $stable(req_addr_o) && $stable(req_we_o)
    );

endmodule

`default_nettype wire

// ==== hw/mem_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      flush_i,
    input  wire                      data_ok_i,
    input  wire [lsu_pkg::XLEN-1:0]  rdata_i,
    pipe_if.down                     up,
    pipe_if.up                       down
);
    import lsu_pkg::*;

    logic [3:0]        state_q;
    logic [3:0]        state_d;
    logic [1:0]        op_q;
    logic [XLEN-1:0]   addr_q;
    logic [REG_AW-1:0] rd_q;
    logic [2:0]        funct3_q;
    // side buffer for a load word that arrived while write-back was stalled
    logic [XLEN-1:0]   buf_q;
    logic              load_q;
    logic              data_here;
    logic              leave;
    logic              take;
    logic              wait_ok;

    assign load_q = (op_q == OP_LOAD);

    // result is ready in FULL, or in PIPE once a load's data shows up
    assign data_here = state_q[S_FULL] || (state_q[S_PIPE] && (!load_q || data_ok_i));
    assign leave     = data_here && down.ready;

    // a response is owed to this stage
    assign wait_ok = state_q[S_DRAIN] || (state_q[S_PIPE] && load_q);

    // the RAM is still busy in the data_ok cycle, so no new op then
    assign up.ready = state_q[S_EMPTY] || (leave && !(state_q[S_PIPE] && load_q));
    assign take     = up.valid && up.ready && !flush_i;

    assign down.valid  = data_here;
    assign down.op     = op_q;
    // loads swap the address for the loaded word
    assign down.addr   = state_q[S_FULL] ? buf_q : (load_q ? rdata_i : addr_q);
    // the byte offset still travels downstream for alignment
    assign down.wdata  = addr_q;
    assign down.rd     = rd_q;
    assign down.funct3 = funct3_q;

    always_comb begin
        state_d = '0;
        if (flush_i) begin
            // an orphaned load response has to be waited out
            if (wait_ok && !data_ok_i) begin
                state_d[S_DRAIN] = 1'b1;
            end else begin
                state_d[S_EMPTY] = 1'b1;
            end
        end else if (state_q[S_DRAIN]) begin
            if (data_ok_i) begin
                state_d[S_EMPTY] = 1'b1;
            end else begin
                state_d[S_DRAIN] = 1'b1;
            end
        end else if (take) begin
            state_d[S_PIPE] = 1'b1;
        end else if (state_q[S_EMPTY] || leave) begin
            state_d[S_EMPTY] = 1'b1;
        end else if (state_q[S_PIPE] && load_q && data_ok_i) begin
            // data came but write-back is stalled
            state_d[S_FULL] = 1'b1;
        end else begin
            state_d = state_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= 4'b0001 << S_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q     <= up.op;
            addr_q   <= up.addr;
            rd_q     <= up.rd;
            funct3_q <= up.funct3;
        end
        if (state_q[S_PIPE] && load_q && data_ok_i && !down.ready) begin
            buf_q <= rdata_i;
        end
    end

    a_state_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(state_q)
    );

    // the RAM only answers a load that this stage holds or drains
    a_no_stray_ok: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_ok_i |-> state_q[S_DRAIN] || (state_q[S_PIPE] && load_q)
    );

endmodule

`default_nettype wire

// ==== hw/pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pipe_if;
    import lsu_pkg::*;

    logic              valid;
    logic              ready;
    logic [1:0]        op;
    // result or effective address; after mem_wb it holds the load word
    logic [XLEN-1:0]   addr;
    // store data; after mem_wb it holds the effective address
    logic [XLEN-1:0]   wdata;
    logic [REG_AW-1:0] rd;
    logic [2:0]        funct3;

    modport up (
        output valid, op, addr, wdata, rd, funct3,
        input  ready
    );

    modport down (
        input  valid, op, addr, wdata, rd, funct3,
        output ready
    );

endinterface

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        we_i,
    input  wire [lsu_pkg::REG_AW-1:0]  wa_i,
    input  wire [lsu_pkg::XLEN-1:0]    wd_i,
    input  wire [lsu_pkg::REG_AW-1:0]  ra_i,
    output logic [lsu_pkg::XLEN-1:0]   rd_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    // x0 is never written and keeps its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd_o = regs[ra_i];

endmodule

`default_nettype wire

// ==== hw/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush_i,
    pipe_if.down                       up,
    output logic                       ret_valid_o,
    input  wire                        ret_ready_i,
    output logic [lsu_pkg::REG_AW-1:0] ret_rd_o,
    output logic [lsu_pkg::XLEN-1:0]   ret_data_o
);
    import lsu_pkg::*;

    load_word_t      lw;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic [XLEN-1:0] ext_data;

    assign lw = up.addr;

    // pick by the low bits of the effective address
    assign sel_byte = lw.bytes[up.wdata[1:0]];
    assign sel_half = lw.halves[up.wdata[1]];

    always_comb begin
        if (up.op != OP_LOAD) begin
            ext_data = up.addr;
        end else begin
            case (up.funct3)
                F3_LB:   ext_data = {{(XLEN-8){sel_byte[7]}}, sel_byte};
                F3_LBU:  ext_data = {{(XLEN-8){1'b0}}, sel_byte};
                F3_LH:   ext_data = {{(XLEN-16){sel_half[15]}}, sel_half};
                F3_LHU:  ext_data = {{(XLEN-16){1'b0}}, sel_half};
                F3_LW:   ext_data = lw;
                default: ext_data = lw;
            endcase
        end
    end

    assign up.ready = !ret_valid_o || ret_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_valid_o <= 1'b0;
        end else if (flush_i) begin
            ret_valid_o <= 1'b0;
        end else if (up.ready) begin
            ret_valid_o <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            ret_rd_o   <= up.rd;
            ret_data_o <= ext_data;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_lsu_wb -o tb_lsu_wb \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_lsu_wb)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
